// File: bench/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exu_tb;
  import exu_pkg::*;
  import rv_isa_pkg::*;

  // roughly 350 cycles of tests, the limit leaves a wide margin
  localparam int max_cycles = 4000;

  logic       clk;
  logic       rstn;
  logic       id_valid;
  logic       id_ready;
  word_t      pc, src1, src2, imm, csr, alu_a, alu_b;
  opcode_t    opcode;
  logic [2:0] funct;
  reg_addr_t  rd;
  alu_funct_t alu_funct;
  logic       alu_funcs;
  word_t      npc, gpr_wdata, csr_wdata1, csr_wdata2;
  logic       gpr_wen, csr_wen1, csr_wen2;
  reg_addr_t  gpr_waddr;
  csr_addr_t  csr_waddr1, csr_waddr2;

  int errors;
  int test_base;
  int tests_run;
  int tests_ok;
  int cycles = 0;

  exu_top i_dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_csr_addr(input string name, input csr_addr_t exp, input csr_addr_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  task automatic begin_test();
    test_base = errors;
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors - test_base;
    tests_run++;
    if (n == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n);
    end
  endtask

  // reference results, straight from the RV32I rules
  function automatic word_t alu_result(word_t a, word_t b, alu_funct_t f, logic s);
    word_t r;
    word_t ones;
    int    sh;
    ones = '1;
    sh   = int'(b[4:0]);
    case (f)
      alu_add:  r = s ? a - b : a + b;
      alu_sll:  r = a << sh;
      alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
      alu_xor:  r = a ^ b;
      alu_sr: begin
        r = a >> sh;
        if (s && a[31]) r = r | ~(ones >> sh); // fill with the sign
      end
      alu_or:   r = a | b;
      default:  r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(br_funct_t f, word_t a, word_t b);
    case (f)
      beq:     return a == b;
      bne:     return a != b;
      blt:     return $signed(a) < $signed(b);
      bge:     return $signed(a) >= $signed(b);
      bltu:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic word_t load_value(word_t w, logic [1:0] off, mem_func_t f);
    logic [7:0]  b8;
    logic [15:0] h16;
    case (off)
      2'd0:    b8 = w[7:0];
      2'd1:    b8 = w[15:8];
      2'd2:    b8 = w[23:16];
      default: b8 = w[31:24];
    endcase
    h16 = off[1] ? w[31:16] : w[15:0];
    case (f)
      mem_b:   return {{24{b8[7]}}, b8};
      mem_bu:  return {24'h0, b8};
      mem_h:   return {{16{h16[15]}}, h16};
      mem_hu:  return {16'h0, h16};
      default: return w;
    endcase
  endfunction

  task automatic drive_op(input opcode_t op, input logic [2:0] f3, input reg_addr_t dst,
                          input word_t pc_v, input word_t s1, input word_t s2,
                          input word_t imm_v, input word_t csr_v, input word_t a,
                          input word_t b, input alu_funct_t af, input logic afs);
    opcode    <= op;
    funct     <= f3;
    rd        <= dst;
    pc        <= pc_v;
    src1      <= s1;
    src2      <= s2;
    imm       <= imm_v;
    csr       <= csr_v;
    alu_a     <= a;
    alu_b     <= b;
    alu_funct <= af;
    alu_funcs <= afs;
    id_valid  <= 1'b1;
  endtask

  // called at a negedge with id_ready high, accepted on the next edge
  task automatic take_op(input string name, input word_t exp_npc);
    check_word({name, " npc"}, exp_npc, npc);
    @(posedge clk);
    id_valid <= 1'b0;
  endtask

  task automatic issue_op(input string name, input word_t exp_npc);
    @(negedge clk);
    while (!id_ready) @(negedge clk);
    take_op(name, exp_npc);
  endtask

  task automatic expect_wb(input string name, input reg_addr_t dst, input word_t exp);
    @(negedge clk);
    while (!gpr_wen) @(negedge clk);
    check_reg({name, " rd"}, dst, gpr_waddr);
    check_word({name, " data"}, exp, gpr_wdata);
  endtask

  task automatic expect_quiet(input string name);
    @(negedge clk);
    check_bit({name, " gpr_wen"}, 1'b0, gpr_wen);
    check_bit({name, " csr_wen1"}, 1'b0, csr_wen1);
    check_bit({name, " csr_wen2"}, 1'b0, csr_wen2);
  endtask

  task automatic run_store(input string name, input word_t addr, input word_t val,
                           input mem_func_t f);
    word_t pc_v;
    pc_v = $urandom & ~32'h3;
    @(posedge clk);
    drive_op(op_store, f, 5'd0, pc_v, addr, val, 32'd0, 32'd0, addr, 32'd0, alu_add, 1'b0);
    issue_op(name, pc_v + 32'd4);
    @(negedge clk);
    check_bit({name, " id_ready"}, 1'b0, id_ready);
    while (!id_ready) begin
      check_bit({name, " gpr_wen"}, 1'b0, gpr_wen);
      @(negedge clk);
    end
  endtask

  task automatic run_load(input string name, input word_t addr, input mem_func_t f,
                          input word_t exp);
    word_t     pc_v;
    reg_addr_t dst;
    pc_v = $urandom & ~32'h3;
    dst  = reg_addr_t'($urandom_range(31, 1));
    @(posedge clk);
    drive_op(op_load, f, dst, pc_v, addr, 32'd0, 32'd0, 32'd0, addr, 32'd0, alu_add, 1'b0);
    issue_op(name, pc_v + 32'd4);
    @(negedge clk);
    check_bit({name, " id_ready"}, 1'b0, id_ready);
    expect_wb(name, dst, exp);
    check_bit({name, " id_ready at wb"}, 1'b0, id_ready);
  endtask

  task automatic arith_writeback();
    word_t      pc_v, a, b, imm_v, exp;
    reg_addr_t  dst;
    alu_funct_t f;
    logic       s;
    logic [31:0] r;
    opcode_t    op;
    string      name;
    begin_test();
    @(negedge clk);
    check_bit("reset id_ready", 1'b1, id_ready);
    check_bit("reset gpr_wen", 1'b0, gpr_wen);
    check_bit("reset csr_wen1", 1'b0, csr_wen1);
    check_bit("reset csr_wen2", 1'b0, csr_wen2);
    for (int i = 0; i < 16; i++) begin
      name  = $sformatf("arith %0d", i);
      pc_v  = $urandom & ~32'h3;
      a     = $urandom;
      b     = $urandom;
      imm_v = $urandom;
      r     = $urandom;
      f     = alu_funct_t'(r[2:0]);
      s     = r[3];
      dst   = r[8:4];
      case (i % 4)
        0: begin
          op  = op_calri;
          b   = imm_v;
          exp = alu_result(a, b, f, s);
        end
        1: begin
          op  = op_calrr;
          exp = alu_result(a, b, f, s);
        end
        2: begin
          op    = op_lui;
          imm_v = imm_v & 32'hfffff000;
          a     = 32'd0;
          b     = imm_v;
          f     = alu_add;
          s     = 1'b0;
          exp   = imm_v;
        end
        default: begin
          op    = op_auipc;
          imm_v = imm_v & 32'hfffff000;
          a     = pc_v;
          b     = imm_v;
          f     = alu_add;
          s     = 1'b0;
          exp   = pc_v + imm_v;
        end
      endcase
      @(posedge clk);
      drive_op(op, f, dst, pc_v, a, b, imm_v, 32'd0, a, b, f, s);
      issue_op(name, pc_v + 32'd4);
      expect_wb(name, dst, exp);
      check_bit({name, " id_ready"}, 1'b1, id_ready); // no stall for alu ops
    end
    end_test("arithmetic writeback");
  endtask

  task automatic control_flow();
    word_t      pc_v, a, b, imm_v, exp;
    reg_addr_t  dst;
    br_funct_t  conds [6];
    br_funct_t  cond;
    alu_funct_t f;
    logic       s;
    string      name;
    begin_test();
    conds = '{beq, bne, blt, bge, bltu, bgeu};
    pc_v  = $urandom & ~32'h3;
    imm_v = $urandom & ~32'h1;
    dst   = reg_addr_t'($urandom_range(31, 1));
    @(posedge clk);
    drive_op(op_jal, 3'd0, dst, pc_v, 32'd0, 32'd0, imm_v, 32'd0, pc_v, 32'd4, alu_add, 1'b0);
    issue_op("jal", pc_v + imm_v);
    expect_wb("jal link", dst, pc_v + 32'd4);
    // odd target, bit 0 must be dropped
    a     = $urandom | 32'h1;
    imm_v = $urandom & ~32'h1;
    pc_v  = $urandom & ~32'h3;
    @(posedge clk);
    drive_op(op_jalr, 3'd0, dst, pc_v, a, 32'd0, imm_v, 32'd0, pc_v, 32'd4, alu_add, 1'b0);
    issue_op("jalr", (a + imm_v) & ~32'h1);
    expect_wb("jalr link", dst, pc_v + 32'd4);
    for (int k = 0; k < 12; k++) begin
      cond = conds[k / 2];
      a    = $urandom;
      b    = (k % 2 == 0) ? a : $urandom; // equal operands every other try
      case (cond)
        beq, bne: begin
          f = alu_add;
          s = 1'b1;
        end
        blt, bge: begin
          f = alu_slt;
          s = 1'b0;
        end
        default: begin
          f = alu_sltu;
          s = 1'b0;
        end
      endcase
      pc_v  = $urandom & ~32'h3;
      imm_v = $urandom & ~32'h1;
      exp   = branch_taken(cond, a, b) ? pc_v + imm_v : pc_v + 32'd4;
      name  = $sformatf("%s %0d", cond.name(), k % 2);
      @(posedge clk);
      drive_op(op_branch, cond, 5'd0, pc_v, a, b, imm_v, 32'd0, a, b, f, s);
      issue_op(name, exp);
      expect_quiet(name);
    end
    end_test("control flow");
  endtask

  task automatic store_load_round_trip();
    word_t      addr, w, bv, hv, ref_w;
    logic [7:0] lanes [4];
    addr = $urandom & 32'h3fc;
    w    = $urandom;
    bv   = $urandom;
    hv   = $urandom;
    begin_test();
    run_store("sw", addr, w, mem_w);
    lanes[0] = w[7:0];
    lanes[1] = w[15:8];
    lanes[2] = w[23:16];
    lanes[3] = w[31:24];
    run_store("sb", addr + 32'd1, bv, mem_b);
    lanes[1] = bv[7:0];
    run_store("sh", addr + 32'd2, hv, mem_h);
    lanes[2] = hv[7:0]; // little endian, low byte first
    lanes[3] = hv[15:8];
    ref_w = {lanes[3], lanes[2], lanes[1], lanes[0]};
    for (int off = 0; off < 4; off++) begin
      run_load($sformatf("lb +%0d", off), addr + word_t'(off), mem_b,
               load_value(ref_w, off[1:0], mem_b));
      run_load($sformatf("lbu +%0d", off), addr + word_t'(off), mem_bu,
               load_value(ref_w, off[1:0], mem_bu));
      if (off % 2 == 0) begin
        run_load($sformatf("lh +%0d", off), addr + word_t'(off), mem_h,
                 load_value(ref_w, off[1:0], mem_h));
        run_load($sformatf("lhu +%0d", off), addr + word_t'(off), mem_hu,
                 load_value(ref_w, off[1:0], mem_hu));
      end
    end
    run_load("lw", addr, mem_w, ref_w);
    end_test("store/load round trip");
  endtask

  task automatic csr_and_system();
    word_t     pc_v, a, csr_v, imm_v;
    reg_addr_t dst;
    begin_test();
    pc_v  = $urandom & ~32'h3;
    a     = $urandom;
    csr_v = $urandom;
    imm_v = $urandom & 32'hfff;
    dst   = reg_addr_t'($urandom_range(31, 1));
    @(posedge clk);
    drive_op(op_sys, 3'b010, dst, pc_v, a, 32'd0, imm_v, csr_v, a, csr_v, alu_or, 1'b0); // csrrs
    issue_op("csrrs", pc_v + 32'd4);
    @(negedge clk);
    check_bit("csrrs gpr_wen", 1'b1, gpr_wen);
    check_reg("csrrs rd", dst, gpr_waddr);
    check_word("csrrs old csr", csr_v, gpr_wdata);
    check_bit("csrrs csr_wen1", 1'b1, csr_wen1);
    check_csr_addr("csrrs csr_waddr1", imm_v[11:0], csr_waddr1);
    check_word("csrrs csr_wdata1", a | csr_v, csr_wdata1);
    check_bit("csrrs csr_wen2", 1'b0, csr_wen2);
    pc_v  = $urandom & ~32'h3;
    csr_v = $urandom & ~32'h3; // trap vector
    @(posedge clk);
    drive_op(op_sys, 3'b000, 5'd0, pc_v, 32'd0, 32'd0, 32'd0, csr_v, pc_v, 32'd0, alu_add, 1'b0);
    issue_op("ecall", csr_v);
    @(negedge clk);
    check_bit("ecall gpr_wen", 1'b0, gpr_wen);
    check_bit("ecall csr_wen1", 1'b1, csr_wen1);
    check_csr_addr("ecall mepc addr", 12'h341, csr_waddr1);
    check_word("ecall mepc", pc_v, csr_wdata1);
    check_bit("ecall csr_wen2", 1'b1, csr_wen2);
    check_csr_addr("ecall mcause addr", 12'h342, csr_waddr2);
    check_word("ecall mcause", 32'd11, csr_wdata2);
    csr_v = $urandom | 32'h1;
    @(posedge clk);
    drive_op(op_sys, 3'b000, 5'd0, pc_v, 32'd0, 32'd0, 32'h302, csr_v, pc_v, 32'd0,
             alu_add, 1'b0);
    issue_op("mret", csr_v & ~32'h1);
    expect_quiet("mret");
    end_test("csr and system");
  endtask

  task automatic load_back_pressure();
    word_t     addr, w, pc1, pc2, pc3, a, b, imm_v;
    reg_addr_t dl, d2, d3;
    logic      seen;
    begin_test();
    addr = $urandom & 32'h3fc;
    w    = $urandom;
    pc1  = $urandom & ~32'h3;
    pc2  = pc1 + 32'd4;
    pc3  = pc2 + 32'd4;
    dl   = reg_addr_t'($urandom_range(31, 1));
    d2   = reg_addr_t'($urandom_range(31, 1));
    d3   = reg_addr_t'($urandom_range(31, 1));
    a    = $urandom;
    b    = $urandom;
    imm_v = $urandom;
    run_store("bp sw", addr, w, mem_w);
    @(posedge clk);
    drive_op(op_load, mem_w, dl, pc1, addr, 32'd0, 32'd0, 32'd0, addr, 32'd0, alu_add, 1'b0);
    issue_op("bp lw", pc1 + 32'd4);
    // next op waits with id_valid high
    drive_op(op_calrr, alu_xor, d2, pc2, a, b, 32'd0, 32'd0, a, b, alu_xor, 1'b0);
    seen = 1'b0;
    @(negedge clk);
    while (!id_ready) begin
      if (gpr_wen) begin
        check_reg("bp lw rd", dl, gpr_waddr);
        check_word("bp lw data", w, gpr_wdata);
        seen = 1'b1;
      end
      @(negedge clk);
    end
    if (!seen) note_failure("bp: id_ready came back before the load wrote its register");
    take_op("bp xor", pc2 + 32'd4);
    drive_op(op_calri, alu_add, d3, pc3, a, 32'd0, imm_v, 32'd0, a, imm_v, alu_add, 1'b0);
    @(negedge clk);
    check_bit("bp xor gpr_wen", 1'b1, gpr_wen);
    check_reg("bp xor rd", d2, gpr_waddr);
    check_word("bp xor data", a ^ b, gpr_wdata);
    check_bit("bp id_ready", 1'b1, id_ready);
    take_op("bp addi", pc3 + 32'd4);
    expect_wb("bp addi", d3, a + imm_v);
    end_test("back-pressure");
  endtask

  initial begin
    void'($urandom(32'h58fc1d61));
    rstn      = 1'b1;
    id_valid  = 1'b0;
    pc        = '0;
    src1      = '0;
    src2      = '0;
    imm       = '0;
    csr       = '0;
    alu_a     = '0;
    alu_b     = '0;
    opcode    = op_calri;
    funct     = 3'd0;
    rd        = '0;
    alu_funct = alu_add;
    alu_funcs = 1'b0;
    errors    = 0;
    test_base = 0;
    tests_run = 0;
    tests_ok  = 0;
    repeat (16) @(posedge clk);
    rstn <= 1'b0;
    arith_writeback();
    control_flow();
    store_load_round_trip();
    csr_and_system();
    load_back_pressure();
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run, tests_ok,
             tests_run - tests_ok, errors);
    if (errors == 0 && tests_ok == tests_run) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f verilog.f --top-module exu_tb -o exu_sim; then
  echo "compile failed"
  exit 1
fi

if ! ./obj_dir/exu_sim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -F -q "*** TEST FAILED ***" sim.log; then
  exit 1
fi

exit 0

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  exu_pkg::word_t         alu_a,
  input  exu_pkg::word_t         alu_b,
  input  rv_isa_pkg::alu_funct_t funct,
  input  logic                   funcs,
  output exu_pkg::word_t         val
);
  import exu_pkg::*;
  import rv_isa_pkg::*;

  logic [4:0] shamt;
  word_t      sra_val;

  assign shamt = alu_b[4:0];
  // kept apart so the shift stays signed
  assign sra_val = $signed(alu_a) >>> shamt;

  always_comb begin
    case (funct)
      alu_add:  val = funcs ? alu_a - alu_b : alu_a + alu_b;
      alu_sll:  val = alu_a << shamt;
      alu_slt:  val = word_t'($signed(alu_a) < $signed(alu_b)); // 0 or 1
      alu_sltu: val = word_t'(alu_a < alu_b);
      alu_xor:  val = alu_a ^ alu_b;
      alu_sr:   val = funcs ? sra_val : alu_a >> shamt;
      alu_or:   val = alu_a | alu_b;
      alu_and:  val = alu_a & alu_b;
      default:  val = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
  input  logic                  clk,
  input  logic                  rstn,
  input  exu_pkg::word_t        pc,
  input  exu_pkg::word_t        src1,
  input  exu_pkg::word_t        src2,
  input  exu_pkg::word_t        imm,
  input  exu_pkg::word_t        csr,
  input  rv_isa_pkg::opcode_t   opcode,
  input  logic [2:0]            funct,
  input  exu_pkg::reg_addr_t    rd,
  input  exu_pkg::word_t        alu_val,
  input  logic                  id_valid,
  output logic                  id_ready,
  output exu_pkg::word_t        npc,
  output logic                  gpr_wen,
  output exu_pkg::reg_addr_t    gpr_waddr,
  output exu_pkg::word_t        gpr_wdata,
  output logic                  csr_wen1,
  output exu_pkg::csr_addr_t    csr_waddr1,
  output exu_pkg::word_t        csr_wdata1,
  output logic                  csr_wen2,
  output exu_pkg::csr_addr_t    csr_waddr2,
  output exu_pkg::word_t        csr_wdata2,
  lsu_rd_if.exu                 rd_port,
  lsu_wr_if.exu                 wr_port
);
  import exu_pkg::*;
  import rv_isa_pkg::*;

  typedef enum logic [1:0] {st_idle, st_mem, st_wb} state_t;

  state_t state;
  logic   fire, is_load, is_store, csr_op, ecall, csr_jump, br_taken;
  logic   id_gpr_wen, id_csr_wen1;
  logic   rd_res_hs, wr_res_hs;
  word_t  id_gpr_wdata, npc_base, npc_inc, npc_sum;

  assign id_ready = (state == st_idle); // busy while a load/store is out
  assign fire     = id_valid & id_ready;
  assign is_load  = (opcode == op_load);
  assign is_store = (opcode == op_store);
  assign csr_op   = (opcode == op_sys) && (funct != 3'b000);
  assign csr_jump = (opcode == op_sys) && (funct == 3'b000); // ecall or mret
  assign ecall    = csr_jump && (imm[11:0] == 12'h000);

  assign rd_res_hs = rd_port.res_valid & rd_port.res_ready;
  assign wr_res_hs = wr_port.res_valid & wr_port.res_ready;

  // compare result from the alu, zero flag for beq/bne
  always_comb begin
    case (br_funct_t'(funct))
      beq:       br_taken = ~|alu_val;
      bne:       br_taken = |alu_val;
      blt, bltu: br_taken = alu_val[0];
      bge, bgeu: br_taken = ~alu_val[0];
      default:   br_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jal, op_jalr: npc_inc = imm;
      op_branch:       npc_inc = br_taken ? imm : word_t'(4);
      op_sys:          npc_inc = csr_jump ? '0 : word_t'(4);
      default:         npc_inc = word_t'(4);
    endcase
  end

  assign npc_base = (opcode == op_jalr) ? src1 : (csr_jump ? csr : pc);
  assign npc_sum  = npc_base + npc_inc;
  assign npc      = npc_sum & ~word_t'(1);

  always_comb begin
    case (opcode)
      op_lui, op_auipc, op_jal, op_jalr, op_calri, op_calrr: id_gpr_wen = 1'b1;
      op_sys:  id_gpr_wen = csr_op; // csr read lands in rd
      default: id_gpr_wen = 1'b0;   // load writes back later
    endcase
  end

  assign id_gpr_wdata = csr_op ? csr : alu_val;
  assign id_csr_wen1  = csr_op | ecall;

  // mcause write is fixed
  assign csr_waddr2 = csr_mcause;
  assign csr_wdata2 = word_t'(cause_ecall_m);

  always_ff @(posedge clk) begin
    if (rstn) begin
      state             <= st_idle;
      gpr_wen           <= 1'b0;
      csr_wen1          <= 1'b0;
      csr_wen2          <= 1'b0;
      rd_port.req_valid <= 1'b0;
      rd_port.res_ready <= 1'b0;
      wr_port.req_valid <= 1'b0;
      wr_port.res_ready <= 1'b0;
    end else begin
      gpr_wen  <= 1'b0; // pulses only
      csr_wen1 <= 1'b0;
      csr_wen2 <= 1'b0;
      case (state)
        st_idle: begin
          if (fire && is_load) begin
            rd_port.req_valid <= 1'b1;
            rd_port.res_ready <= 1'b1;
            state             <= st_mem;
          end else if (fire && is_store) begin
            wr_port.req_valid <= 1'b1;
            wr_port.res_ready <= 1'b1;
            state             <= st_mem;
          end else if (fire) begin
            gpr_wen  <= id_gpr_wen;
            csr_wen1 <= id_csr_wen1;
            csr_wen2 <= ecall;
          end
        end
        st_mem: begin
          if (rd_port.req_ready) rd_port.req_valid <= 1'b0;
          if (wr_port.req_ready) wr_port.req_valid <= 1'b0;
          if (rd_res_hs) begin
            rd_port.res_ready <= 1'b0;
            gpr_wen           <= 1'b1;
            state             <= st_wb;
          end
          if (wr_res_hs) begin
            wr_port.res_ready <= 1'b0;
            state             <= st_idle; // store done on the response edge
          end
        end
        default: state <= st_idle; // st_wb, one cycle for the load pulse
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      gpr_waddr     <= rd;
      gpr_wdata     <= id_gpr_wdata;
      csr_waddr1    <= csr_op ? imm[11:0] : csr_mepc;
      csr_wdata1    <= alu_val;
      rd_port.addr  <= alu_val;
      rd_port.func  <= mem_func_t'(funct);
      wr_port.addr  <= alu_val;
      wr_port.func  <= mem_func_t'(funct);
      wr_port.wdata <= src2;
    end
    if (rd_res_hs) gpr_wdata <= rd_port.rdata;
  end

endmodule

`default_nettype wire

// File: source/exu_pkg.sv
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

  // access size, same encoding as load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_func_t;

  typedef logic [`XLEN-1:0] word_t;

  typedef logic [11:0] csr_addr_t;

  typedef logic [4:0] reg_addr_t; // x0..x31

endpackage

`default_nettype wire

// File: source/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data and address width of the execute path
`define XLEN 32

// data memory depth, counted in words
`define DMEM_WORDS 256

// cycles between an accepted lsu request and its response
`define LSU_LATENCY 2

`endif

// File: source/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   id_valid,
  output logic                   id_ready,
  input  exu_pkg::word_t         pc,
  input  rv_isa_pkg::opcode_t    opcode,
  input  logic [2:0]             funct,
  input  exu_pkg::reg_addr_t     rd,
  input  exu_pkg::word_t         src1,
  input  exu_pkg::word_t         src2,
  input  exu_pkg::word_t         imm,
  input  exu_pkg::word_t         csr,
  input  exu_pkg::word_t         alu_a,
  input  exu_pkg::word_t         alu_b,
  input  rv_isa_pkg::alu_funct_t alu_funct,
  input  logic                   alu_funcs,
  output exu_pkg::word_t         npc,
  output logic                   gpr_wen,
  output exu_pkg::reg_addr_t     gpr_waddr,
  output exu_pkg::word_t         gpr_wdata,
  output logic                   csr_wen1,
  output exu_pkg::csr_addr_t     csr_waddr1,
  output exu_pkg::word_t         csr_wdata1,
  output logic                   csr_wen2,
  output exu_pkg::csr_addr_t     csr_waddr2,
  output exu_pkg::word_t         csr_wdata2
);
  import exu_pkg::*;

  word_t alu_val;

  lsu_rd_if rd_bus ();
  lsu_wr_if wr_bus ();

  alu i_alu (
    .alu_a (alu_a),
    .alu_b (alu_b),
    .funct (alu_funct),
    .funcs (alu_funcs),
    .val   (alu_val)
  );

  exu i_exu (
    .clk        (clk),
    .rstn       (rstn),
    .pc         (pc),
    .src1       (src1),
    .src2       (src2),
    .imm        (imm),
    .csr        (csr),
    .opcode     (opcode),
    .funct      (funct),
    .rd         (rd),
    .alu_val    (alu_val),
    .id_valid   (id_valid),
    .id_ready   (id_ready),
    .npc        (npc),
    .gpr_wen    (gpr_wen),
    .gpr_waddr  (gpr_waddr),
    .gpr_wdata  (gpr_wdata),
    .csr_wen1   (csr_wen1),
    .csr_waddr1 (csr_waddr1),
    .csr_wdata1 (csr_wdata1),
    .csr_wen2   (csr_wen2),
    .csr_waddr2 (csr_waddr2),
    .csr_wdata2 (csr_wdata2),
    .rd_port    (rd_bus.exu),
    .wr_port    (wr_bus.exu)
  );

  lsu i_lsu (
    .clk     (clk),
    .rstn    (rstn),
    .rd_port (rd_bus.lsu),
    .wr_port (wr_bus.lsu)
  );

endmodule

`default_nettype wire

// File: source/lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module lsu (
  input logic   clk,
  input logic   rstn,
  lsu_rd_if.lsu rd_port,
  lsu_wr_if.lsu wr_port
);
  import exu_pkg::*;

  localparam int AW = $clog2(`DMEM_WORDS);
  localparam int CW = $clog2(`LSU_LATENCY + 1);

  word_t         mem [`DMEM_WORDS];
  logic          busy, is_rd, rd_req_hs, wr_req_hs, res_hs;
  logic [CW-1:0] count;
  logic [3:0]    be;
  word_t         wdata_sh, rword, ld_val;
  logic [7:0]    rbyte;
  logic [15:0]   rhalf;

  assign rd_port.req_ready = ~busy;
  assign wr_port.req_ready = ~busy & ~rd_port.req_valid; // reads win a tie
  assign rd_port.res_valid = busy & is_rd & (count == '0);
  assign wr_port.res_valid = busy & ~is_rd & (count == '0);

  assign rd_req_hs = rd_port.req_valid & rd_port.req_ready;
  assign wr_req_hs = wr_port.req_valid & wr_port.req_ready;
  assign res_hs    = (rd_port.res_valid & rd_port.res_ready) |
                     (wr_port.res_valid & wr_port.res_ready);

  // byte enables and lane replication for stores
  always_comb begin
    case (wr_port.func)
      mem_b, mem_bu: begin
        be       = 4'b0001 << wr_port.addr[1:0];
        wdata_sh = {4{wr_port.wdata[7:0]}};
      end
      mem_h, mem_hu: begin
        be       = 4'b0011 << {wr_port.addr[1], 1'b0};
        wdata_sh = {2{wr_port.wdata[15:0]}};
      end
      default: begin
        be       = 4'b1111;
        wdata_sh = wr_port.wdata;
      end
    endcase
  end

  assign rword = mem[rd_port.addr[AW+1:2]];
  assign rbyte = rword[{rd_port.addr[1:0], 3'b000} +: 8];
  assign rhalf = rword[{rd_port.addr[1], 4'b0000} +: 16];

  always_comb begin
    case (rd_port.func)
      mem_b:   ld_val = {{24{rbyte[7]}}, rbyte};
      mem_bu:  ld_val = {24'b0, rbyte};
      mem_h:   ld_val = {{16{rhalf[15]}}, rhalf};
      mem_hu:  ld_val = {16'b0, rhalf};
      default: ld_val = rword;
    endcase
  end

  always_ff @(posedge clk) begin
    if (wr_req_hs) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mem[wr_port.addr[AW+1:2]][i*8 +: 8] <= wdata_sh[i*8 +: 8];
      end
    end
    if (rd_req_hs) rd_port.rdata <= ld_val; // held until the response
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy  <= 1'b0;
      is_rd <= 1'b0;
      count <= '0;
    end else if (rd_req_hs | wr_req_hs) begin
      busy  <= 1'b1;
      is_rd <= rd_req_hs;
      count <= CW'(`LSU_LATENCY);
    end else if (busy && count != '0) begin
      count <= count - 1'b1;
    end else if (res_hs) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/lsu_if.sv
`timescale 1ns/1ps
`default_nettype none

// load channel between exu and lsu
interface lsu_rd_if;
  import exu_pkg::*;

  logic      req_valid;
  logic      req_ready;
  word_t     addr;
  mem_func_t func;
  logic      res_valid;
  logic      res_ready;
  word_t     rdata;

  modport exu (output req_valid, addr, func, res_ready,
               input  req_ready, res_valid, rdata);
  modport lsu (input  req_valid, addr, func, res_ready,
               output req_ready, res_valid, rdata);
endinterface

// store channel, response carries no data
interface lsu_wr_if;
  import exu_pkg::*;

  logic      req_valid;
  logic      req_ready;
  word_t     addr;
  mem_func_t func;
  word_t     wdata;
  logic      res_valid;
  logic      res_ready;

  modport exu (output req_valid, addr, func, wdata, res_ready,
               input  req_ready, res_valid);
  modport lsu (input  req_valid, addr, func, wdata, res_ready,
               output req_ready, res_valid);
endinterface

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes, inst[6:2] as produced by the decoder
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_calri  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_calrr  = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } opcode_t;

  // branch conditions in funct3 encoding
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } br_funct_t;

  // alu ops, funcs picks sub / sra
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_sr   = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_funct_t;

  localparam logic [11:0] csr_mepc   = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;

  localparam int unsigned cause_ecall_m = 11; // environment call from m-mode

endpackage

`default_nettype wire

// File: verilog.f
+incdir+source
source/rv_isa_pkg.sv
source/exu_pkg.sv
source/lsu_if.sv
source/alu.sv
source/exu.sv
source/lsu.sv
source/exu_top.sv
bench/exu_tb.sv
